//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tetris_tb -Mdir obj_dir
out=$(./obj_dir/Vtetris_tb 2>&1) || true
echo "$out"
echo "$out" | grep -q "^Done: no errors$"

//--- tb.f
+incdir+verilog
verilog/tetris_board_pkg.sv
verilog/tetris_game_pkg.sv
verilog/piece_if.sv
verilog/piece_sequencer.sv
verilog/piece_mover.sv
verilog/line_clearer.sv
verilog/game_controller.sv
verilog/tetris_top.sv
verif/tetris_assert.sv
verif/tetris_tb.sv

//--- verif/tetris_assert.sv
`timescale 1ns/1ps

module tetris_assert import tetris_game_pkg::*; (
    input logic        clk,
    input logic        reset,
    input game_state_t state_i,
    input logic        spawn_i,
    input logic        gameover_i,
    input logic [7:0]  score_i
);

    // SPAWN is a single cycle
    spawn_one_cycle: assert property (@(posedge clk) disable iff (reset)
        state_i == SPAWN |=> state_i == FALLING)
        else $error("SPAWN lasted more than one cycle");

    spawn_gameover_excl: assert property (@(posedge clk) disable iff (reset)
        !(spawn_i && gameover_i))
        else $error("spawn_o and gameover_o high together");

    gameover_sticky: assert property (@(posedge clk) disable iff (reset)
        gameover_i |=> gameover_i)
        else $error("gameover_o dropped");

    score_monotonic: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> score_i >= $past(score_i))
        else $error("score_o decreased");

endmodule

// Controller state and clearer score are seen through the top level wires
bind tetris_top tetris_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .state_i    (state),
    .spawn_i    (spawn_o),
    .gameover_i (gameover_o),
    .score_i    (score_o)
);

//--- verif/tetris_tb.sv
`timescale 1ns/1ps
`include "tetris_params.svh"

module tetris_tb import tetris_board_pkg::*, tetris_game_pkg::*; ();

    // One table line per piece, dir 0 none, 1 left, 2 right
    typedef struct packed {
        logic [1:0]  dir;
        logic [3:0]  hold;
        piece_kind_t kind;
        logic [7:0]  score;
    } step_t;

    localparam int NUM_STEPS = 27;
    localparam int WATCHDOG_CYCLES = NUM_STEPS * 60 * 4 + 200;

    // First seven pieces fill row 19 so the T piece clears it, the rest stack up
    step_t steps [NUM_STEPS] = '{
        '{2'd1, 4'd10, LINE, 8'd0}, '{2'd1, 4'd3, SQUARE, 8'd0},
        '{2'd1, 4'd1, L_PIECE, 8'd0}, '{2'd2, 4'd1, J_PIECE, 8'd0},
        '{2'd0, 4'd0, S_PIECE, 8'd0}, '{2'd0, 4'd0, Z_PIECE, 8'd0},
        '{2'd2, 4'd10, T_PIECE, 8'd1}, '{2'd0, 4'd0, LINE, 8'd1},
        '{2'd0, 4'd0, SQUARE, 8'd1}, '{2'd0, 4'd0, L_PIECE, 8'd1},
        '{2'd0, 4'd0, J_PIECE, 8'd1}, '{2'd0, 4'd0, S_PIECE, 8'd1},
        '{2'd0, 4'd0, Z_PIECE, 8'd1}, '{2'd0, 4'd0, T_PIECE, 8'd1},
        '{2'd0, 4'd0, LINE, 8'd1}, '{2'd0, 4'd0, SQUARE, 8'd1},
        '{2'd0, 4'd0, L_PIECE, 8'd1}, '{2'd0, 4'd0, J_PIECE, 8'd1},
        '{2'd0, 4'd0, S_PIECE, 8'd1}, '{2'd0, 4'd0, Z_PIECE, 8'd1},
        '{2'd0, 4'd0, T_PIECE, 8'd1}, '{2'd0, 4'd0, LINE, 8'd1},
        '{2'd0, 4'd0, SQUARE, 8'd1}, '{2'd0, 4'd0, L_PIECE, 8'd1},
        '{2'd0, 4'd0, J_PIECE, 8'd1}, '{2'd0, 4'd0, S_PIECE, 8'd1},
        '{2'd0, 4'd0, Z_PIECE, 8'd1}
    };

    logic        clk = 1'b0;
    logic        reset;
    logic        tick_i;
    logic        start_i;
    logic        left_i;
    logic        right_i;
    board_t      board_o;
    piece_kind_t piece_kind_o;
    logic        spawn_o;
    logic        gameover_o;
    logic [7:0]  score_o;

    // Reference model state
    board_t      m_board;
    logic [7:0]  m_score;
    logic        m_over;
    piece_kind_t m_kind;
    row_idx_t    m_row;
    col_idx_t    m_col;
    int          seed = 52;

    tetris_top u_dut (.*);

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_board(input board_t got, input board_t exp);
        if (got !== exp)
            report_failure($sformatf("Error: board_o got %h expected %h", got, exp));
    endtask

    task automatic check_kind(input piece_kind_t got, input piece_kind_t exp);
        if (got !== exp)
            report_failure($sformatf("Error: piece_kind_o got %h expected %h", got, exp));
    endtask

    task automatic check_score(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            report_failure($sformatf("Error: score_o got %h expected %h", got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    // Shapes as {row3, row2, row1, row0}, bit c of a row is column c
    function automatic pattern_t shape_of(input piece_kind_t k);
        case (k)
            LINE:    return {4'b0010, 4'b0010, 4'b0010, 4'b0010};
            SQUARE:  return {4'b0000, 4'b0000, 4'b0110, 4'b0110};
            L_PIECE: return {4'b0000, 4'b0110, 4'b0010, 4'b0010};
            J_PIECE: return {4'b0000, 4'b0110, 4'b0100, 4'b0100};
            S_PIECE: return {4'b0000, 4'b0000, 4'b0110, 4'b1100};
            Z_PIECE: return {4'b0000, 4'b0000, 4'b1100, 4'b0110};
            default: return {4'b0000, 4'b0000, 4'b1110, 4'b0100};
        endcase
    endfunction

    // Active piece on an empty board, cells off the board are dropped
    function automatic board_t draw_piece();
        board_t   ov;
        pattern_t p;
        row_idx_t pr;
        col_idx_t pc;

        ov = '0;
        p  = shape_of(m_kind);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                pr = m_row + row_idx_t'(r);
                pc = m_col + col_idx_t'(c);
                if (p[r][c] && pr < `BOARD_ROWS && pc < `BOARD_COLS)
                    ov[pr][pc] = 1'b1;
            end
        end
        return ov;
    endfunction

    // One gravity tick, a sideways step needs both the current and the next row free
    task automatic model_tick(input logic l, input logic r, output logic landed);
        board_t ov;
        logic   bot;
        logic   lb;
        logic   rb;

        ov  = draw_piece();
        bot = |ov[`BOARD_ROWS-1];
        lb  = 1'b0;
        rb  = 1'b0;
        for (int k = 0; k < `BOARD_ROWS; k++) begin
            lb |= ov[k][0] || |(ov[k] & (m_board[k] << 1)) || |(ov[k] & (m_board[k+1] << 1));
            rb |= ov[k][`BOARD_COLS-1] || |(ov[k] & (m_board[k] >> 1)) ||
                  |(ov[k] & (m_board[k+1] >> 1));
            if (k < `BOARD_ROWS - 1)
                bot |= |(ov[k] & m_board[k+1]);
        end
        landed = bot;
        if (!bot) begin
            m_row = m_row + 5'd1;
            if (l && !lb)
                m_col = m_col - 4'd1;
            else if (r && !rb)
                m_col = m_col + 4'd1;
        end
    endtask

    // Lock, then clear full rows from the bottom up
    task automatic model_lock();
        int r;

        if (|m_board[0]) begin
            m_over = 1'b1;
        end else begin
            m_board = m_board | draw_piece();
            r = `BOARD_ROWS - 1;
            while (r >= 0) begin
                if (&m_board[r]) begin
                    if (m_score != `SCORE_MAX)
                        m_score++;
                    for (int k = r; k > 0; k--)
                        m_board[k] = m_board[k-1];
                    m_board[0] = '0;
                end else begin
                    r--;
                end
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("Watchdog expired, the game stalled before the tests finished");
    end

    initial begin
        int   gap;
        int   n;
        logic landed;

        reset   = 1'b1;
        tick_i  = 1'b0;
        start_i = 1'b0;
        left_i  = 1'b0;
        right_i = 1'b0;
        m_board = '0;
        m_score = '0;
        m_over  = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_board(board_o, '0);
        check_score(score_o, 8'd0);
        check_flag("spawn_o", spawn_o, 1'b0);
        check_flag("gameover_o", gameover_o, 1'b0);
        check_kind(piece_kind_o, LINE);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;

        for (int i = 0; i < NUM_STEPS; i++) begin
            while (!spawn_o && !gameover_o)
                @(negedge clk);
            if (i > 0)
                check_score(score_o, steps[i-1].score);
            check_score(score_o, m_score);
            check_board(board_o, m_board);
            if (gameover_o) begin
                if (!m_over)
                    report_failure("Game over came earlier than the model predicts");
                break;
            end
            if (m_over)
                report_failure("A new piece spawned where the model expects game over");
            check_kind(piece_kind_o, steps[i].kind);
            m_kind = steps[i].kind;
            m_row  = '0;
            m_col  = col_idx_t'(`SPAWN_COL);
            @(negedge clk);
            landed = 1'b0;
            n      = 0;
            while (!landed) begin
                gap = 1 + ($unsigned($random(seed)) % 4);
                repeat (gap) @(negedge clk);
                tick_i  = 1'b1;
                left_i  = (steps[i].dir == 2'd1) && (n < steps[i].hold);
                right_i = (steps[i].dir == 2'd2) && (n < steps[i].hold);
                @(negedge clk);
                model_tick(left_i, right_i, landed);
                tick_i  = 1'b0;
                left_i  = 1'b0;
                right_i = 1'b0;
                n++;
            end
            model_lock();
        end

        while (!spawn_o && !gameover_o)
            @(negedge clk);
        if (!gameover_o)
            report_failure("The game never reached game over");

        // Inputs keep coming, nothing may change
        repeat (8) begin
            tick_i = 1'b1;
            left_i = ~left_i;
            @(negedge clk);
            tick_i = 1'b0;
            @(negedge clk);
        end
        check_flag("gameover_o", gameover_o, 1'b1);
        check_board(board_o, m_board);
        check_score(score_o, m_score);

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- verilog/game_controller.sv
`timescale 1ns/1ps

module game_controller import tetris_board_pkg::*, tetris_game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start_i,
    input  logic        tick_i,
    input  logic        bottom_hit_i,
    input  logic        eval_done_i,
    input  board_t      stored_i,
    input  board_t      cleared_i,
    input  board_t      overlay_i,
    output game_state_t state_o,
    output board_t      board_o,
    output logic        spawn_o,
    output logic        gameover_o
);

    game_state_t state;
    game_state_t next_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= INIT;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            INIT: begin
                if (start_i)
                    next_state = SPAWN;
            end
            SPAWN:   next_state = FALLING;
            FALLING: begin
                // Landing is only noticed on a gravity tick
                if (tick_i && bottom_hit_i)
                    next_state = STUCK;
            end
            STUCK: begin
                if (|stored_i[0])
                    next_state = GAMEOVER;
                else
                    next_state = LANDED;
            end
            LANDED:  next_state = EVAL;
            EVAL: begin
                if (eval_done_i)
                    next_state = SPAWN;
            end
            GAMEOVER: next_state = GAMEOVER;
            default:  next_state = INIT;
        endcase
    end

    // Display source per state
    always_comb begin
        case (state)
            SPAWN, FALLING, STUCK: board_o = stored_i | overlay_i;
            EVAL:                  board_o = cleared_i;
            default:               board_o = stored_i;
        endcase
    end

    assign state_o    = state;
    assign spawn_o    = (state == SPAWN);
    assign gameover_o = (state == GAMEOVER);

endmodule

//--- verilog/line_clearer.sv
`timescale 1ns/1ps
`include "tetris_params.svh"

module line_clearer import tetris_board_pkg::*, tetris_game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  game_state_t state_i,
    piece_if.clear_mp   piece,
    output board_t      stored_o,
    output board_t      cleared_o,
    output logic        eval_done_o,
    output logic [7:0]  score_o
);

    localparam row_idx_t   LAST_ROW  = row_idx_t'(`BOARD_ROWS - 1);
    localparam logic [7:0] SCORE_SAT = 8'(`SCORE_MAX);

    board_t     stored;
    board_t     scan;
    board_t     merged;
    row_idx_t   scan_row;
    logic       eval_done;
    logic       row_full;
    logic [7:0] score;

    assign merged   = stored | piece.overlay;
    assign row_full = &scan[scan_row];

    // Locked board, scan pointer and score
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stored    <= '0;
            scan_row  <= LAST_ROW;
            eval_done <= 1'b0;
            score     <= '0;
        end else begin
            case (state_i)
                LANDED: begin
                    stored    <= merged;
                    scan_row  <= LAST_ROW;
                    eval_done <= 1'b0;
                end
                EVAL: begin
                    if (eval_done) begin
                        stored <= scan;
                    end else if (row_full) begin
                        // Scan stays on this row, the rows above drop into it
                        if (score != SCORE_SAT)
                            score <= score + 8'd1;
                    end else if (scan_row == '0) begin
                        eval_done <= 1'b1;
                    end else begin
                        scan_row <= scan_row - 5'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Working copy, rows 0 to scan_row move down by one on a full row
    always_ff @(posedge clk) begin
        if (state_i == LANDED) begin
            scan <= merged;
        end else if (state_i == EVAL && !eval_done && row_full) begin
            for (int k = 0; k < `BOARD_ROWS; k++) begin
                if (k == 0)
                    scan[0] <= '0;
                else if (k <= int'(scan_row))
                    scan[k] <= scan[k-1];
            end
        end
    end

    assign stored_o    = stored;
    assign cleared_o   = scan;
    assign eval_done_o = eval_done;
    assign score_o     = score;

endmodule

//--- verilog/piece_if.sv
`timescale 1ns/1ps

interface piece_if import tetris_board_pkg::*, tetris_game_pkg::*; ();

    // Active piece shape
    piece_kind_t kind;
    pattern_t    pattern;

    // Position, drawn piece and landing flag
    row_idx_t    row;
    col_idx_t    col;
    board_t      overlay;
    logic        bottom_hit;

    modport seq_mp (
        output kind,
        output pattern
    );

    modport mover_mp (
        input  kind,
        input  pattern,
        output row,
        output col,
        output overlay,
        output bottom_hit
    );

    modport clear_mp (
        input  overlay
    );

endinterface

//--- verilog/piece_mover.sv
`timescale 1ns/1ps
`include "tetris_params.svh"

module piece_mover import tetris_board_pkg::*, tetris_game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  game_state_t state_i,
    input  logic        tick_i,
    input  logic        left_i,
    input  logic        right_i,
    input  board_t      stored_i,
    piece_if.mover_mp   piece
);

    localparam row_idx_t LAST_ROW = row_idx_t'(`BOARD_ROWS - 1);
    localparam col_idx_t LAST_COL = col_idx_t'(`BOARD_COLS - 1);

    row_idx_t pos_row;
    col_idx_t pos_col;
    logic     piece_live;
    board_t   overlay;
    logic     bottom_blk;
    logic     left_blk;
    logic     right_blk;

    // Position update, moves only on gravity ticks
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos_row    <= '0;
            pos_col    <= col_idx_t'(`SPAWN_COL);
            piece_live <= 1'b0;
        end else begin
            case (state_i)
                SPAWN: begin
                    pos_row    <= '0;
                    pos_col    <= col_idx_t'(`SPAWN_COL);
                    piece_live <= 1'b1;
                end
                FALLING: begin
                    if (tick_i && !bottom_blk) begin
                        pos_row <= pos_row + 5'd1;
                        // Left wins when both are held
                        if (left_i && !left_blk)
                            pos_col <= pos_col - 4'd1;
                        else if (right_i && !right_blk)
                            pos_col <= pos_col + 4'd1;
                    end
                end
                // Piece is merged into the stored board this cycle
                LANDED: piece_live <= 1'b0;
                default: ;
            endcase
        end
    end

    // Overlay drawing and collision checks over the 4x4 box.
    // Column arithmetic wraps, so an empty pattern column 0 may sit left of the wall
    always_comb begin
        row_idx_t cell_row;
        col_idx_t cell_col;

        overlay    = '0;
        bottom_blk = 1'b0;
        left_blk   = 1'b0;
        right_blk  = 1'b0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                cell_row = pos_row + row_idx_t'(r);
                cell_col = pos_col + col_idx_t'(c);
                if (piece_live && piece.pattern[r][c] &&
                    cell_row <= LAST_ROW && cell_col <= LAST_COL) begin
                    overlay[cell_row][cell_col] = 1'b1;

                    // Floor or a locked cell right below
                    if (cell_row == LAST_ROW)
                        bottom_blk = 1'b1;
                    else if (stored_i[cell_row + 5'd1][cell_col])
                        bottom_blk = 1'b1;

                    // Sideways moves happen together with the drop,
                    // so the row below is checked as well
                    if (cell_col == '0)
                        left_blk = 1'b1;
                    else if (stored_i[cell_row][cell_col - 4'd1])
                        left_blk = 1'b1;
                    else if (cell_row != LAST_ROW &&
                             stored_i[cell_row + 5'd1][cell_col - 4'd1])
                        left_blk = 1'b1;

                    if (cell_col == LAST_COL)
                        right_blk = 1'b1;
                    else if (stored_i[cell_row][cell_col + 4'd1])
                        right_blk = 1'b1;
                    else if (cell_row != LAST_ROW &&
                             stored_i[cell_row + 5'd1][cell_col + 4'd1])
                        right_blk = 1'b1;
                end
            end
        end
    end

    assign piece.row        = pos_row;
    assign piece.col        = pos_col;
    assign piece.overlay    = overlay;
    assign piece.bottom_hit = bottom_blk;

endmodule

//--- verilog/piece_sequencer.sv
`timescale 1ns/1ps

module piece_sequencer import tetris_board_pkg::*, tetris_game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  game_state_t state_i,
    piece_if.seq_mp     piece,
    output piece_kind_t next_kind_o
);

    piece_kind_t next_kind;
    piece_kind_t active_kind;

    // Kind counter steps once per spawn, the spawning kind becomes active
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            next_kind   <= LINE;
            active_kind <= LINE;
        end else if (state_i == SPAWN) begin
            active_kind <= next_kind;
            if (next_kind == T_PIECE)
                next_kind <= LINE;
            else
                next_kind <= piece_kind_t'(next_kind + 3'd1);
        end
    end

    assign piece.kind  = active_kind;
    assign next_kind_o = next_kind;

    // Fixed shapes, bit index within a row is the column
    always_comb begin
        piece.pattern = '0;
        case (piece.kind)
            LINE: begin
                piece.pattern[0] = 4'b0010;
                piece.pattern[1] = 4'b0010;
                piece.pattern[2] = 4'b0010;
                piece.pattern[3] = 4'b0010;
            end
            SQUARE: begin
                piece.pattern[0] = 4'b0110;
                piece.pattern[1] = 4'b0110;
            end
            L_PIECE: begin
                piece.pattern[0] = 4'b0010;
                piece.pattern[1] = 4'b0010;
                piece.pattern[2] = 4'b0110;
            end
            J_PIECE: begin
                piece.pattern[0] = 4'b0100;
                piece.pattern[1] = 4'b0100;
                piece.pattern[2] = 4'b0110;
            end
            S_PIECE: begin
                piece.pattern[0] = 4'b1100;
                piece.pattern[1] = 4'b0110;
            end
            Z_PIECE: begin
                piece.pattern[0] = 4'b0110;
                piece.pattern[1] = 4'b1100;
            end
            T_PIECE: begin
                piece.pattern[0] = 4'b0100;
                piece.pattern[1] = 4'b1110;
            end
            default: piece.pattern = '0;
        endcase
    end

endmodule

//--- verilog/tetris_board_pkg.sv
`include "tetris_params.svh"

package tetris_board_pkg;

    // One board row, bit index is the column
    typedef logic [`BOARD_COLS-1:0] row_t;

    // Row 0 is the top of the playfield
    typedef row_t [`BOARD_ARRAY_ROWS-1:0] board_t;

    // Piece cells indexed [row][col] inside the 4x4 box
    typedef logic [3:0][3:0] pattern_t;

    // Board coordinates of the top left corner of the 4x4 box
    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

endpackage

//--- verilog/tetris_game_pkg.sv
package tetris_game_pkg;

    typedef enum logic [2:0] {
        INIT     = 3'd0,
        SPAWN    = 3'd1,
        FALLING  = 3'd2,
        STUCK    = 3'd3,
        LANDED   = 3'd4,
        EVAL     = 3'd5,
        GAMEOVER = 3'd6
    } game_state_t;

    // Spawn order follows the encoding
    typedef enum logic [2:0] {
        LINE    = 3'd0,
        SQUARE  = 3'd1,
        L_PIECE = 3'd2,
        J_PIECE = 3'd3,
        S_PIECE = 3'd4,
        Z_PIECE = 3'd5,
        T_PIECE = 3'd6
    } piece_kind_t;

endpackage

//--- verilog/tetris_params.svh
`ifndef TETRIS_PARAMS_SVH
`define TETRIS_PARAMS_SVH

// Visible playfield height, the lowest row index is one less
`define BOARD_ROWS 20

// Rows held in the board array, two spare rows below the playfield
`define BOARD_ARRAY_ROWS 22

// Playfield width
`define BOARD_COLS 10

// Left column of the 4x4 pattern when a piece appears
`define SPAWN_COL 3

// Cleared-row counter stops here
`define SCORE_MAX 255

`endif

//--- verilog/tetris_top.sv
`timescale 1ns/1ps

module tetris_top import tetris_board_pkg::*, tetris_game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        tick_i,
    input  logic        start_i,
    input  logic        left_i,
    input  logic        right_i,
    output board_t      board_o,
    output piece_kind_t piece_kind_o,
    output logic        spawn_o,
    output logic        gameover_o,
    output logic [7:0]  score_o
);

    game_state_t state;
    board_t      stored;
    board_t      cleared;
    logic        eval_done;

    piece_if u_piece_bus ();

    piece_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .state_i     (state),
        .piece       (u_piece_bus.seq_mp),
        .next_kind_o (piece_kind_o)
    );

    piece_mover u_mover (
        .clk      (clk),
        .reset    (reset),
        .state_i  (state),
        .tick_i   (tick_i),
        .left_i   (left_i),
        .right_i  (right_i),
        .stored_i (stored),
        .piece    (u_piece_bus.mover_mp)
    );

    line_clearer u_clearer (
        .clk         (clk),
        .reset       (reset),
        .state_i     (state),
        .piece       (u_piece_bus.clear_mp),
        .stored_o    (stored),
        .cleared_o   (cleared),
        .eval_done_o (eval_done),
        .score_o     (score_o)
    );

    game_controller u_controller (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start_i),
        .tick_i       (tick_i),
        .bottom_hit_i (u_piece_bus.bottom_hit),
        .eval_done_i  (eval_done),
        .stored_i     (stored),
        .cleared_i    (cleared),
        .overlay_i    (u_piece_bus.overlay),
        .state_o      (state),
        .board_o      (board_o),
        .spawn_o      (spawn_o),
        .gameover_o   (gameover_o)
    );

endmodule
